//--- logic/ctrl_settings.svh
/*
  Core controller build settings
  Widths shared by the controller package and the RTL blocks
*/

`ifndef CTRL_SETTINGS_SVH
`define CTRL_SETTINGS_SVH

//////////////////////////////////////////////////////////////
// datapath
//////////////////////////////////////////////////////////////

// data and address width
`define CTRL_XLEN 32

//////////////////////////////////////////////////////////////
// interrupts and causes
//////////////////////////////////////////////////////////////

// fast interrupt lines and the index width that covers them
`define CTRL_NUM_FAST_IRQ 15
`define CTRL_FAST_ID_W 4
// mcause code width with the interrupt flag in the msb
`define CTRL_CAUSE_W 6

`endif

//--- logic/ctrl_pkg.sv
/*
  Core controller types
  Vectors, enums and bundles shared by the controller blocks
*/

`default_nettype none

`include "ctrl_settings.svh"

package ctrl_pkg;

  typedef logic [`CTRL_XLEN-1:0]         word_t;
  typedef logic [15:0]                   half_t;
  typedef logic [`CTRL_NUM_FAST_IRQ-1:0] fast_irq_t;
  typedef logic [`CTRL_FAST_ID_W-1:0]    fast_id_t;

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // fetch address source
  typedef enum logic [1:0] {PC_BOOT, PC_JUMP, PC_EXC, PC_ERET} pc_sel_e;

  // handler base selector
  typedef enum logic {EXC_PC_EXC, EXC_PC_IRQ} exc_pc_sel_e;

  // interrupts set the msb and fast lines also set bit 4 with the index below it
  typedef enum logic [`CTRL_CAUSE_W-1:0] {
    EXC_CAUSE_IRQ_SOFTWARE_M     = {1'b1, 5'd3},
    EXC_CAUSE_IRQ_TIMER_M        = {1'b1, 5'd7},
    EXC_CAUSE_IRQ_EXTERNAL_M     = {1'b1, 5'd11},
    EXC_CAUSE_IRQ_FAST_0         = {1'b1, 5'd16},
    EXC_CAUSE_IRQ_FAST_14        = {1'b1, 5'd30},
    EXC_CAUSE_IRQ_NM             = {1'b1, 5'd31},
    EXC_CAUSE_INSN_ADDR_MISA     = {1'b0, 5'd0},
    EXC_CAUSE_INSTR_ACCESS_FAULT = {1'b0, 5'd1},
    EXC_CAUSE_ILLEGAL_INSN       = {1'b0, 5'd2},
    EXC_CAUSE_BREAKPOINT         = {1'b0, 5'd3},
    EXC_CAUSE_LOAD_ACCESS_FAULT  = {1'b0, 5'd5},
    EXC_CAUSE_STORE_ACCESS_FAULT = {1'b0, 5'd7},
    EXC_CAUSE_ECALL_UMODE        = {1'b0, 5'd8},
    EXC_CAUSE_ECALL_MMODE        = {1'b0, 5'd11}
  } exc_cause_e;

  typedef enum logic [3:0] {
    RESET, BOOT_SET, WAIT_SLEEP, SLEEP, FIRST_FETCH, DECODE, FLUSH, IRQ_TAKEN
  } ctrl_fsm_e;

  typedef struct packed {
    logic      irq_software;
    logic      irq_timer;
    logic      irq_external;
    fast_irq_t irq_fast;
  } irqs_t;

  // decoder flags not yet qualified with instruction valid
  typedef struct packed {
    logic illegal;
    logic ecall;
    logic mret;
    logic wfi;
    logic ebrk;
    logic dret;
    logic csr_flush;
  } dec_flags_t;

  // instruction held in the fetch/decode register
  typedef struct packed {
    word_t instr;
    half_t instr_c;
    logic  is_compressed;
    logic  fetch_err;
    logic  fetch_err_plus2;
    word_t pc;
  } instr_info_t;

  typedef struct packed {
    logic        pc_set;
    logic        pc_set_spec;
    pc_sel_e     pc_mux;
    exc_pc_sel_e exc_pc_mux;
  } pc_req_t;

  typedef struct packed {
    logic save_if;
    logic save_id;
    logic restore_mret;
    logic save_cause;
  } csr_save_t;

endpackage

`default_nettype wire

//--- logic/exc_prioritizer.sv
/*
  Exception prioritizer
  Registers fault requests, picks the winning one by fixed priority
  and works out its mcause code and mtval
*/

`default_nettype none

module exc_prioritizer import ctrl_pkg::*; (
  input  wire logic        clk_i,
  input  wire logic        rst_ni,
  input  wire dec_flags_t  dec_i,
  input  wire instr_info_t instr_i,
  input  wire logic        instr_valid_i,
  input  wire priv_lvl_e   priv_mode_i,
  input  wire logic        csr_mstatus_tw_i,
  input  wire logic        load_err_i,
  input  wire logic        store_err_i,
  input  wire word_t       lsu_addr_last_i,
  input  wire logic        in_flush_i,
  output logic             exc_pending_o,
  output logic             lsu_exc_o,
  output logic             special_req_o,
  output logic             pc_change_req_o,
  output exc_cause_e       exc_cause_o,
  output word_t            mtval_o
);

  logic  fetch_err;
  logic  illegal_umode;
  logic  illegal_d, illegal_q;
  logic  exc_req_d, exc_req_q;
  logic  load_err_q, store_err_q;
  word_t mtval;

  // decoder flags arrive qualified but the fetch error does not
  assign fetch_err = instr_i.fetch_err & instr_valid_i;

  // mret and trapped wfi need M-mode
  assign illegal_umode = (priv_mode_i != PRIV_LVL_M) &
                         (dec_i.mret | (csr_mstatus_tw_i & dec_i.wfi));

  // no debug mode, so dret is always illegal
  assign illegal_d = (dec_i.illegal | dec_i.dret | illegal_umode) & ~in_flush_i;
  assign exc_req_d = (dec_i.ecall | dec_i.ebrk | illegal_d | fetch_err) & ~in_flush_i;

  assign lsu_exc_o       = load_err_i | store_err_i;
  assign pc_change_req_o = dec_i.mret | dec_i.dret | exc_req_d;
  // wfi and csr writes only flush while pc changes redirect fetch
  assign special_req_o   = pc_change_req_o | dec_i.wfi | dec_i.csr_flush;
  assign exc_pending_o   = exc_req_q | load_err_q | store_err_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      illegal_q   <= 1'b0;
      exc_req_q   <= 1'b0;
      load_err_q  <= 1'b0;
      store_err_q <= 1'b0;
    end else begin
      illegal_q   <= illegal_d;
      exc_req_q   <= exc_req_d;
      load_err_q  <= load_err_i & ~in_flush_i;
      store_err_q <= store_err_i & ~in_flush_i;
    end
  end

  //////////////////////////////////////////////////////////////
  // fixed priority where the first match wins
  //////////////////////////////////////////////////////////////

  always_comb begin
    exc_cause_o = EXC_CAUSE_INSN_ADDR_MISA;
    mtval       = '0;
    if (fetch_err) begin
      exc_cause_o = EXC_CAUSE_INSTR_ACCESS_FAULT;
      // fault in the upper half of an unaligned fetch
      mtval       = instr_i.fetch_err_plus2 ? (instr_i.pc + word_t'(2)) : instr_i.pc;
    end else if (illegal_q) begin
      exc_cause_o = EXC_CAUSE_ILLEGAL_INSN;
      mtval       = instr_i.is_compressed ? word_t'(instr_i.instr_c) : instr_i.instr;
    end else if (dec_i.ecall) begin
      exc_cause_o = (priv_mode_i == PRIV_LVL_M) ? EXC_CAUSE_ECALL_MMODE :
                                                  EXC_CAUSE_ECALL_UMODE;
    end else if (dec_i.ebrk) begin
      exc_cause_o = EXC_CAUSE_BREAKPOINT;
    end else if (store_err_q) begin
      exc_cause_o = EXC_CAUSE_STORE_ACCESS_FAULT;
      mtval       = lsu_addr_last_i;
    end else if (load_err_q) begin
      exc_cause_o = EXC_CAUSE_LOAD_ACCESS_FAULT;
      mtval       = lsu_addr_last_i;
    end
  end

  // mtval only valid while the fault is taken
  assign mtval_o = (in_flush_i & exc_pending_o) ? mtval : '0;

endmodule

`default_nettype wire

//--- logic/irq_arbiter.sv
/*
  Interrupt arbiter
  Decides whether an interrupt is taken, picks its cause, tracks NMI mode
*/

`default_nettype none

`include "ctrl_settings.svh"

module irq_arbiter import ctrl_pkg::*; (
  input  wire logic  clk_i,
  input  wire logic  rst_ni,
  input  wire irqs_t irqs_i,
  input  wire logic  irq_nm_i,
  input  wire logic  irq_pending_i,
  input  wire logic  csr_mstatus_mie_i,
  input  wire logic  irq_take_i,
  input  wire logic  mret_done_i,
  output logic       handle_irq_o,
  output exc_cause_e irq_cause_o,
  output logic       nmi_mode_o
);

  logic     nmi_mode_q;
  fast_id_t mfip_id;

  // nested NMIs unsupported, NMI mode masks everything
  assign handle_irq_o = ~nmi_mode_q & (irq_nm_i | (irq_pending_i & csr_mstatus_mie_i));

  // highest fast index wins, later iterations override
  always_comb begin
    mfip_id = '0;
    for (int unsigned i = 0; i < `CTRL_NUM_FAST_IRQ; i++) begin
      if (irqs_i.irq_fast[i]) begin
        mfip_id = fast_id_t'(i);
      end
    end
  end

  always_comb begin
    if (irq_nm_i && !nmi_mode_q) begin
      irq_cause_o = EXC_CAUSE_IRQ_NM;
    end else if (|irqs_i.irq_fast) begin
      // 0b11 prefix puts fast line n at code 16+n
      irq_cause_o = exc_cause_e'({2'b11, mfip_id});
    end else if (irqs_i.irq_external) begin
      irq_cause_o = EXC_CAUSE_IRQ_EXTERNAL_M;
    end else if (irqs_i.irq_software) begin
      irq_cause_o = EXC_CAUSE_IRQ_SOFTWARE_M;
    end else if (irqs_i.irq_timer) begin
      irq_cause_o = EXC_CAUSE_IRQ_TIMER_M;
    end else begin
      irq_cause_o = EXC_CAUSE_INSN_ADDR_MISA;
    end
  end

  // set on NMI entry, left by the handler's mret
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      nmi_mode_q <= 1'b0;
    end else if (irq_take_i && irq_nm_i && !nmi_mode_q) begin
      nmi_mode_q <= 1'b1;
    end else if (mret_done_i) begin
      nmi_mode_q <= 1'b0;
    end
  end

  assign nmi_mode_o = nmi_mode_q;

endmodule

`default_nettype wire

//--- logic/ctrl_fsm.sv
/*
  Controller state machine
  Boot, decode, flush, sleep and interrupt entry with stall and flush control
*/

`default_nettype none

module ctrl_fsm import ctrl_pkg::*; (
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  input  wire logic       instr_valid_i,
  input  wire dec_flags_t dec_i,
  input  wire logic       exc_pending_i,
  input  wire logic       lsu_exc_i,
  input  wire logic       special_req_i,
  input  wire exc_cause_e exc_cause_i,
  input  wire logic       handle_irq_i,
  input  wire exc_cause_e irq_cause_i,
  input  wire logic       irq_pending_i,
  input  wire logic       irq_nm_i,
  input  wire logic       branch_set_i,
  input  wire logic       branch_set_spec_i,
  input  wire logic       jump_set_i,
  input  wire logic       stall_id_i,
  output logic            in_flush_o,
  output logic            irq_take_o,
  output logic            mret_done_o,
  output logic            ctrl_busy_o,
  output logic            instr_req_o,
  output logic            id_in_ready_o,
  output logic            instr_valid_clear_o,
  output logic            flush_id_o,
  output logic            controller_run_o,
  output pc_req_t         pc_req_o,
  output csr_save_t       csr_save_o,
  output exc_cause_e      exc_cause_o
);

  ctrl_fsm_e state_q, state_d;
  logic      halt_if, retain_id, flush_id;
  logic      special_req;

  // lsu faults arrive without an ID-stage valid
  assign special_req = special_req_i | lsu_exc_i;

  always_comb begin
    state_d          = state_q;
    instr_req_o      = 1'b1;
    ctrl_busy_o      = 1'b1;
    controller_run_o = 1'b0;
    halt_if          = 1'b0;
    retain_id        = 1'b0;
    flush_id         = 1'b0;
    irq_take_o       = 1'b0;
    mret_done_o      = 1'b0;
    // mux values matter only with pc_set
    pc_req_o         = '{pc_set: 1'b0, pc_set_spec: 1'b0, pc_mux: PC_BOOT,
                         exc_pc_mux: EXC_PC_IRQ};
    csr_save_o       = '0;
    exc_cause_o      = EXC_CAUSE_INSN_ADDR_MISA;

    unique case (state_q)
      RESET, BOOT_SET: begin
        // boot address pushed into fetch twice
        instr_req_o          = (state_q == BOOT_SET);
        pc_req_o.pc_set      = 1'b1;
        pc_req_o.pc_set_spec = 1'b1;
        state_d              = (state_q == RESET) ? BOOT_SET : FIRST_FETCH;
      end
      WAIT_SLEEP, SLEEP: begin
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        ctrl_busy_o = 1'b0;
        if (state_q == WAIT_SLEEP) begin
          state_d = SLEEP;
        end else if (irq_nm_i || irq_pending_i) begin
          // wake on any pending line, even when masked
          ctrl_busy_o = 1'b1;
          state_d     = FIRST_FETCH;
        end
      end
      FIRST_FETCH: begin
        if (id_in_ready_o) begin
          state_d = DECODE;
        end
        if (handle_irq_i && !stall_id_i) begin
          state_d = IRQ_TAKEN;
          halt_if = 1'b1;
        end
      end
      DECODE: begin
        controller_run_o = 1'b1;
        pc_req_o.pc_mux  = PC_JUMP;
        // keep the instruction in ID for the FLUSH decision
        if (special_req) begin
          retain_id = 1'b1;
          state_d   = FLUSH;
        end
        if ((branch_set_i || jump_set_i) && instr_valid_i) begin
          pc_req_o.pc_set = 1'b1;
        end
        if ((branch_set_spec_i || branch_set_i || jump_set_i) && instr_valid_i) begin
          pc_req_o.pc_set_spec = 1'b1;
        end
        // let a stalled instruction finish before the handler jump
        if (handle_irq_i && (stall_id_i || !special_req)) begin
          halt_if = 1'b1;
        end
        if (handle_irq_i && !stall_id_i && !special_req) begin
          state_d = IRQ_TAKEN;
        end
      end
      IRQ_TAKEN: begin
        pc_req_o.pc_mux     = PC_EXC;
        pc_req_o.exc_pc_mux = EXC_PC_IRQ;
        if (handle_irq_i) begin
          pc_req_o.pc_set       = 1'b1;
          pc_req_o.pc_set_spec  = 1'b1;
          csr_save_o.save_if    = 1'b1;
          csr_save_o.save_cause = 1'b1;
          exc_cause_o           = irq_cause_i;
          irq_take_o            = 1'b1;
        end
        state_d = DECODE;
      end
      FLUSH: begin
        halt_if  = 1'b1;
        flush_id = 1'b1;
        state_d  = DECODE;
        if (exc_pending_i) begin
          // epc is the faulting instruction in ID
          pc_req_o              = '{pc_set: 1'b1, pc_set_spec: 1'b1, pc_mux: PC_EXC,
                                    exc_pc_mux: EXC_PC_EXC};
          csr_save_o.save_id    = 1'b1;
          csr_save_o.save_cause = 1'b1;
          exc_cause_o           = exc_cause_i;
        end else if (dec_i.mret) begin
          pc_req_o.pc_mux         = PC_ERET;
          pc_req_o.pc_set         = 1'b1;
          pc_req_o.pc_set_spec    = 1'b1;
          csr_save_o.restore_mret = 1'b1;
          mret_done_o             = 1'b1;
        end else if (dec_i.wfi) begin
          state_d = WAIT_SLEEP;
        end else if (dec_i.csr_flush && handle_irq_i) begin
          // a csr write may have just enabled an interrupt
          state_d = IRQ_TAKEN;
        end
      end
      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////
  // stall and flush
  //////////////////////////////////////////////////////////////

  assign in_flush_o          = (state_q == FLUSH);
  assign flush_id_o          = flush_id;
  assign id_in_ready_o       = ~stall_id_i & ~halt_if & ~retain_id;
  // retained entries stay valid unless flushed
  assign instr_valid_clear_o = ~(stall_id_i | retain_id) | flush_id;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RESET;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

//--- logic/core_controller.sv
/*
  Core controller top level
  Qualifies decoder flags with instruction valid and joins the
  exception, interrupt and state machine blocks
*/

`default_nettype none

module core_controller import ctrl_pkg::*; (
  input  wire logic        clk_i,
  input  wire logic        rst_ni,
  input  wire logic        instr_valid_i,
  input  wire dec_flags_t  dec_i,
  input  wire instr_info_t instr_i,
  input  wire logic        branch_set_i,
  input  wire logic        branch_set_spec_i,
  input  wire logic        jump_set_i,
  input  wire word_t       lsu_addr_last_i,
  input  wire logic        load_err_i,
  input  wire logic        store_err_i,
  input  wire irqs_t       irqs_i,
  input  wire logic        irq_nm_i,
  input  wire logic        irq_pending_i,
  input  wire logic        csr_mstatus_mie_i,
  input  wire priv_lvl_e   priv_mode_i,
  input  wire logic        csr_mstatus_tw_i,
  input  wire logic        stall_id_i,
  output pc_req_t          pc_req_o,
  output csr_save_t        csr_save_o,
  output exc_cause_e       exc_cause_o,
  output word_t            csr_mtval_o,
  output logic             nmi_mode_o,
  output logic             ctrl_busy_o,
  output logic             instr_req_o,
  output logic             id_in_ready_o,
  output logic             instr_valid_clear_o,
  output logic             flush_id_o,
  output logic             controller_run_o
);

  dec_flags_t dec_q;
  logic       in_flush, exc_pending, lsu_exc, special_req;
  logic       handle_irq, irq_take, mret_done;
  exc_cause_e exc_cause, irq_cause;

  // decoder flags do not see instruction valid
  assign dec_q.illegal   = dec_i.illegal & instr_valid_i;
  assign dec_q.ecall     = dec_i.ecall & instr_valid_i;
  assign dec_q.mret      = dec_i.mret & instr_valid_i;
  assign dec_q.wfi       = dec_i.wfi & instr_valid_i;
  assign dec_q.ebrk      = dec_i.ebrk & instr_valid_i;
  assign dec_q.dret      = dec_i.dret & instr_valid_i;
  assign dec_q.csr_flush = dec_i.csr_flush & instr_valid_i;

  exc_prioritizer u_exc_prioritizer (
    .clk_i, .rst_ni, .dec_i(dec_q), .instr_i, .instr_valid_i, .priv_mode_i,
    .csr_mstatus_tw_i, .load_err_i, .store_err_i, .lsu_addr_last_i,
    .in_flush_i(in_flush), .exc_pending_o(exc_pending), .lsu_exc_o(lsu_exc),
    .special_req_o(special_req), .pc_change_req_o(), .exc_cause_o(exc_cause),
    .mtval_o(csr_mtval_o)
  );

  irq_arbiter u_irq_arbiter (
    .clk_i, .rst_ni, .irqs_i, .irq_nm_i, .irq_pending_i, .csr_mstatus_mie_i,
    .irq_take_i(irq_take), .mret_done_i(mret_done), .handle_irq_o(handle_irq),
    .irq_cause_o(irq_cause), .nmi_mode_o
  );

  ctrl_fsm u_ctrl_fsm (
    .clk_i, .rst_ni, .instr_valid_i, .dec_i(dec_q), .exc_pending_i(exc_pending),
    .lsu_exc_i(lsu_exc), .special_req_i(special_req), .exc_cause_i(exc_cause),
    .handle_irq_i(handle_irq), .irq_cause_i(irq_cause), .irq_pending_i, .irq_nm_i,
    .branch_set_i, .branch_set_spec_i, .jump_set_i, .stall_id_i,
    .in_flush_o(in_flush), .irq_take_o(irq_take), .mret_done_o(mret_done),
    .ctrl_busy_o, .instr_req_o, .id_in_ready_o, .instr_valid_clear_o, .flush_id_o,
    .controller_run_o, .pc_req_o, .csr_save_o, .exc_cause_o
  );

endmodule

`default_nettype wire

//--- bench/core_controller_assertions.sv
/*
  Core controller assertions
  Handshake and PC request rules, bound into the top level
*/

`default_nettype none

module core_controller_assertions import ctrl_pkg::*; (
  input wire logic      clk_i,
  input wire logic      rst_ni,
  input wire logic      stall_id_i,
  input wire logic      id_in_ready_o,
  input wire pc_req_t   pc_req_o,
  input wire csr_save_t csr_save_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // every committed redirect is also a speculative one
  pc_set_has_spec: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pc_req_o.pc_set |-> pc_req_o.pc_set_spec)
    else $error("pc_set high without pc_set_spec");

  // back-pressure blocks the handshake
  ready_not_stalled: assert property (@(posedge clk_i) disable iff (!rst_ni)
    id_in_ready_o |-> !stall_id_i)
    else $error("id_in_ready_o high while stall_id_i is high");

  // a cause save always comes with a handler jump
  save_cause_has_pc_set: assert property (@(posedge clk_i) disable iff (!rst_ni)
    csr_save_o.save_cause |-> pc_req_o.pc_set)
    else $error("save_cause high without pc_set");

endmodule

`default_nettype wire

//--- bench/core_controller_tb.sv
/*
  Core controller testbench
  Replays the stimulus file, checks boot, causes, mtval, sleep and handshakes
*/

`default_nettype none

module core_controller_tb import ctrl_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        instr_valid_i, branch_set_i, branch_set_spec_i, jump_set_i;
  dec_flags_t  dec_i;
  instr_info_t instr_i;
  word_t       lsu_addr_last_i;
  logic        load_err_i, store_err_i, irq_nm_i, irq_pending_i;
  irqs_t       irqs_i;
  logic        csr_mstatus_mie_i, csr_mstatus_tw_i, stall_id_i;
  priv_lvl_e   priv_mode_i;
  pc_req_t     pc_req_o;
  csr_save_t   csr_save_o;
  exc_cause_e  exc_cause_o;
  word_t       csr_mtval_o;
  logic        nmi_mode_o, ctrl_busy_o, instr_req_o, id_in_ready_o;
  logic        instr_valid_clear_o, flush_id_o, controller_run_o;

  string       lines[$];
  integer      seed = 4430;
  int          errors, failed_tests, limit_ns;
  bit          bad;

  core_controller u_core_controller (.*);

  bind core_controller core_controller_assertions u_core_controller_assertions (.*);

  // 8 ns period
  always #4 clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////

  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  task automatic clear_inputs();
    instr_valid_i = 1'b0;
    dec_i = '0;
    instr_i = '0;
    branch_set_i = 1'b0;
    branch_set_spec_i = 1'b0;
    jump_set_i = 1'b0;
    lsu_addr_last_i = '0;
    load_err_i = 1'b0;
    store_err_i = 1'b0;
    irqs_i = '0;
    irq_nm_i = 1'b0;
    irq_pending_i = 1'b0;
    csr_mstatus_mie_i = 1'b0;
    csr_mstatus_tw_i = 1'b0;
    stall_id_i = 1'b0;
    priv_mode_i = PRIV_LVL_M;
  endtask

  task automatic check_value(input string name, input logic [31:0] got, exp);
    if (got !== exp) begin
      $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
      errors++;
      bad = 1'b1;
    end
  endtask

  task automatic report_error(input string msg);
    $display("ERROR t=%0t %s", $time, msg);
    errors++;
    bad = 1'b1;
  endtask

  // sample at the falling edge where outputs have settled
  task automatic wait_for_pc_set(input pc_sel_e mux);
    bit seen;
    seen = 1'b0;
    for (int i = 0; i < 20 && !seen; i++) begin
      @(negedge clk_i);
      seen = pc_req_o.pc_set && (pc_req_o.pc_mux == mux);
    end
    if (!seen) report_error($sformatf("no pc_set with pc_mux %s in 20 cycles", mux.name()));
  endtask

  // traps pick the handler base and save the pc of the interrupted or faulting instruction
  task automatic compare_handler_entry(input bit is_irq);
    exc_pc_sel_e sel;
    sel = is_irq ? EXC_PC_IRQ : EXC_PC_EXC;
    check_value("exc_pc_mux", pc_req_o.exc_pc_mux, sel);
    check_value("save_cause", csr_save_o.save_cause, 1);
    check_value("save_if", csr_save_o.save_if, is_irq);
    check_value("save_id", csr_save_o.save_id, !is_irq);
    if (!is_irq) check_value("flush_id_o", flush_id_o, 1);
  endtask

  // lowest priority first so higher sources overwrite
  function automatic logic [5:0] expected_irq_cause(input logic [17:0] v);
    logic [5:0] c;
    c = 6'h00;
    if (v[16]) c = 6'h27;
    if (v[17]) c = 6'h23;
    if (v[15]) c = 6'h2b;
    for (int i = 0; i < 15; i++) begin
      if (v[i]) c = 6'h30 + 6'(i);
    end
    return c;
  endfunction

  // ends the run after 40 cycles per stimulus line
  initial begin
    wait (limit_ns > 0);
    #(limit_ns);
    $display("watchdog expired after %0d ns", limit_ns);
    $display("ERRORS FOUND");
    $finish;
  end

  //////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////

  initial begin
    int          fd, rc;
    string       line;
    logic [31:0] code, flags, priv, tw, ferr, p2, comp, instr, instr_c, pc;
    logic [31:0] ld, st, addr, irqs, nm, mie, cause, mtval;

    clear_inputs();
    rst_ni = 1'b0;
    fd = $fopen("bench/controller_stimulus.txt", "r");
    if (fd == 0) begin
      $display("cannot open bench/controller_stimulus.txt");
      $display("ERRORS FOUND");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        rc = $fgets(line, fd);
        if (rc > 0 && line.len() > 1 && line.getc(0) != "#") lines.push_back(line);
      end
      $fclose(fd);
      limit_ns = (lines.size() + 2) * 40 * 8;

      // reset and boot
      bad = 1'b0;
      repeat (8) @(posedge clk_i);
      @(negedge clk_i);
      check_value("instr_req_o", instr_req_o, 0);
      check_value("csr_save_o", csr_save_o, 0);
      check_value("nmi_mode_o", nmi_mode_o, 0);
      step();
      rst_ni = 1'b1;
      @(negedge clk_i);
      check_value("instr_req_o", instr_req_o, 0);
      repeat (2) begin
        check_value("pc_set", pc_req_o.pc_set, 1);
        check_value("pc_mux", pc_req_o.pc_mux, PC_BOOT);
        check_value("ctrl_busy_o", ctrl_busy_o, 1);
        @(negedge clk_i);
      end
      $display("test 0 reset %s", bad ? "failed" : "ok");
      failed_tests += bad;
      repeat (3) step();

      foreach (lines[n]) begin
        bad = 1'b0;
        rc = $sscanf(lines[n], "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                     code, flags, priv, tw, ferr, p2, comp, instr, instr_c, pc,
                     ld, st, addr, irqs, nm, mie, cause, mtval);
        if (rc != 18) report_error($sformatf("stimulus line %0d has %0d fields", n + 1, rc));
        if (code == 7) begin
          irqs = $random(seed) & 32'h3ffff;
          if (irqs == 0) irqs = 32'h10000;
          cause = expected_irq_cause(irqs[17:0]);
        end
        step();
        instr_valid_i = (flags != 0) | ferr[0] | (code == 6);
        dec_i = flags[6:0];
        priv_mode_i = priv_lvl_e'(priv[1:0]);
        csr_mstatus_tw_i = tw[0];
        instr_i = '{instr: instr, instr_c: instr_c[15:0], is_compressed: comp[0],
                    fetch_err: ferr[0], fetch_err_plus2: p2[0], pc: pc};
        load_err_i = ld[0];
        store_err_i = st[0];
        lsu_addr_last_i = addr;
        irqs_i = irqs[17:0];
        irq_pending_i = |irqs[17:0];
        irq_nm_i = nm[0];
        csr_mstatus_mie_i = mie[0];
        stall_id_i = (code == 5);
        branch_set_i = (code == 6);
        branch_set_spec_i = (code == 6);
        case (code)
          0, 1, 7: begin
            wait_for_pc_set(PC_EXC);
            check_value("exc_cause_o", exc_cause_o, cause);
            compare_handler_entry(code != 0);
            if (code == 0) check_value("csr_mtval_o", csr_mtval_o, mtval);
          end
          2: begin
            wait_for_pc_set(PC_EXC);
            check_value("exc_cause_o", exc_cause_o, cause);
            compare_handler_entry(1'b1);
            step();
            clear_inputs();
            @(negedge clk_i);
            check_value("nmi_mode_o", nmi_mode_o, 1);
            step();
            instr_valid_i = 1'b1;
            dec_i.mret = 1'b1;
            wait_for_pc_set(PC_ERET);
            check_value("restore_mret", csr_save_o.restore_mret, 1);
            step();
            clear_inputs();
            @(negedge clk_i);
            check_value("nmi_mode_o", nmi_mode_o, 0);
          end
          3: begin
            repeat (10) begin
              @(negedge clk_i);
              if (pc_req_o.pc_set) report_error("interrupt taken with mie low");
            end
          end
          4: begin
            for (int i = 0; i < 20 && ctrl_busy_o; i++) @(negedge clk_i);
            if (ctrl_busy_o) report_error("ctrl_busy_o stayed high after WFI");
            step();
            instr_valid_i = 1'b0;
            dec_i = '0;
            step();
            irq_pending_i = 1'b1;
            @(negedge clk_i);
            check_value("ctrl_busy_o", ctrl_busy_o, 1);
          end
          5: begin
            repeat (6) begin
              @(negedge clk_i);
              if (pc_req_o.pc_set) report_error("pc_set while stall_id_i was high");
              check_value("id_in_ready_o", id_in_ready_o, 0);
              check_value("instr_valid_clear_o", instr_valid_clear_o, 0);
            end
            step();
            stall_id_i = 1'b0;
            wait_for_pc_set(PC_EXC);
            check_value("exc_cause_o", exc_cause_o, cause);
            compare_handler_entry(1'b1);
          end
          6: begin
            @(negedge clk_i);
            check_value("pc_set", pc_req_o.pc_set, 1);
            check_value("pc_mux", pc_req_o.pc_mux, PC_JUMP);
            check_value("controller_run_o", controller_run_o, 1);
          end
          default: report_error($sformatf("unknown scenario code %0d", code));
        endcase
        step();
        clear_inputs();
        repeat (2) step();
        $display("test %0d code %0d %s", n + 1, code, bad ? "failed" : "ok");
        failed_tests += bad;
      end

      $display("tests %0d failed %0d errors %0d", lines.size() + 1, failed_tests, errors);
      if (errors == 0) begin
        $display("NO ERRORS");
      end else begin
        $display("ERRORS FOUND");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- core_controller.f
+incdir+logic
logic/ctrl_pkg.sv
logic/exc_prioritizer.sv
logic/irq_arbiter.sv
logic/ctrl_fsm.sv
logic/core_controller.sv
bench/core_controller_assertions.sv
bench/core_controller_tb.sv

//--- run_sim.sh
#!/bin/bash
# build and run the core controller testbench with Verilator
set -eo pipefail

verilator --binary --timing --assert -Wno-fatal -f core_controller.f \
  --top-module core_controller_tb -o core_controller_sim

./obj_dir/core_controller_sim | tee sim.log

if grep -q "ERRORS FOUND" sim.log || ! grep -q "NO ERRORS" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"

//--- bench/controller_stimulus.txt
# code flags priv tw ferr p2 comp instr instr_c pc ld st addr irqs nm mie cause mtval
# code 0 exc 1 irq 2 nmi+mret 3 masked 4 wfi 5 stall 6 branch 7 random irq
0 00 3 0 1 0 0 00000013 0000 00001000 0 0 00000000 00000 0 0 01 00001000
0 00 3 0 1 1 0 00000013 0000 00001000 0 0 00000000 00000 0 0 01 00001002
0 40 3 0 1 0 0 ffffffff 0000 00002000 0 0 00000000 00000 0 0 01 00002000
0 40 3 0 0 0 0 0000707f 0000 00003000 0 0 00000000 00000 0 0 02 0000707f
0 40 3 0 0 0 1 00000000 8001 00003004 0 0 00000000 00000 0 0 02 00008001
0 02 3 0 0 0 0 7b200073 0000 00003008 0 0 00000000 00000 0 0 02 7b200073
0 10 0 0 0 0 0 30200073 0000 0000300c 0 0 00000000 00000 0 0 02 30200073
0 08 0 1 0 0 0 10500073 0000 00003010 0 0 00000000 00000 0 0 02 10500073
0 20 3 0 0 0 0 00000073 0000 00003014 0 0 00000000 00000 0 0 0b 00000000
0 20 0 0 0 0 0 00000073 0000 00003018 0 0 00000000 00000 0 0 08 00000000
0 60 3 0 0 0 0 0000000f 0000 0000301c 0 0 00000000 00000 0 0 02 0000000f
0 24 3 0 0 0 0 00000073 0000 00003020 0 0 00000000 00000 0 0 0b 00000000
0 04 3 0 0 0 0 00100073 0000 00003024 1 0 80000004 00000 0 0 03 00000000
0 00 3 0 0 0 0 00000000 0000 00000000 1 1 80000010 00000 0 0 07 80000010
0 00 3 0 0 0 0 00000000 0000 00000000 1 0 80000020 00000 0 0 05 80000020
1 00 3 0 0 0 0 00000000 0000 00000000 0 0 00000000 38000 0 1 2b 00000000
1 00 3 0 0 0 0 00000000 0000 00000000 0 0 00000000 30000 0 1 23 00000000
1 00 3 0 0 0 0 00000000 0000 00000000 0 0 00000000 10000 0 1 27 00000000
1 00 3 0 0 0 0 00000000 0000 00000000 0 0 00000000 0a001 0 1 3d 00000000
1 01 3 0 0 0 0 00000000 0000 00000000 0 0 00000000 00010 0 1 34 00000000
2 00 3 0 0 0 0 00000000 0000 00000000 0 0 00000000 08000 1 1 3f 00000000
3 00 3 0 0 0 0 00000000 0000 00000000 0 0 00000000 38000 0 0 00 00000000
4 08 3 0 0 0 0 10500073 0000 00004000 0 0 00000000 00000 0 0 00 00000000
5 00 3 0 0 0 0 00000000 0000 00000000 0 0 00000000 04000 0 1 3e 00000000
6 00 3 0 0 0 0 00000063 0000 00005000 0 0 00000000 00000 0 0 00 00000000
7 00 3 0 0 0 0 00000000 0000 00000000 0 0 00000000 00000 0 1 00 00000000
7 00 3 0 0 0 0 00000000 0000 00000000 0 0 00000000 00000 0 1 00 00000000
7 00 3 0 0 0 0 00000000 0000 00000000 0 0 00000000 00000 0 1 00 00000000
